// File: build.f
+incdir+tb
hw/sampler_pkg.sv
hw/sampler_fsm.sv
hw/sample_counter.sv
hw/byte_buffer.sv
hw/reject_sampler.sv
hw/cbd_sampler.sv
hw/coef_store.sv
hw/poly_sampler_top.sv
tb/tb_poly_sampler.sv

// File: hw/byte_buffer.sv
`default_nettype none

module byte_buffer (
    input  wire                         clk,
    input  wire                         load,
    input  wire                         busy,
    input  wire sampler_pkg::byte_addr_t load_addr,
    input  wire sampler_pkg::byte_t     load_byte,
    input  wire sampler_pkg::byte_addr_t byte_pos,
    output sampler_pkg::byte_group_t    group
);

    sampler_pkg::byte_t mem [sampler_pkg::BYTE_BUF_DEPTH];

    // Bytes past the end read as zero
    function automatic sampler_pkg::byte_t byte_at(input logic [9:0] addr);
        if (addr < 10'(sampler_pkg::BYTE_BUF_DEPTH)) begin
            return mem[addr[8:0]];
        end
        return '0;
    endfunction

    always_ff @(posedge clk) begin
        if (load && !busy && load_addr < sampler_pkg::byte_addr_t'(sampler_pkg::BYTE_BUF_DEPTH)) begin
            mem[load_addr] <= load_byte;
        end
    end

    always_ff @(posedge clk) begin
        group.b0 <= byte_at(10'(byte_pos));
        group.b1 <= byte_at(10'(byte_pos) + 10'd1);
        group.b2 <= byte_at(10'(byte_pos) + 10'd2);
    end

endmodule

`default_nettype wire

// File: hw/cbd_sampler.sv
`default_nettype none

module cbd_sampler (
    input  wire sampler_pkg::byte_group_t group,
    input  wire sampler_pkg::mode_t       mode_q,
    output sampler_pkg::coef_group_t      coefs
);

    logic [23:0]        bits;
    logic               eta3;
    sampler_pkg::coef_t lane [4];

    // Bit 0 of b0 is consumed first
    assign bits = {group.b2, group.b1, group.b0};
    assign eta3 = (mode_q == sampler_pkg::MODE_CBD3);

    always_comb begin
        logic [5:0] chunk;
        logic [2:0] pos_sum;
        logic [2:0] neg_sum;
        for (int k = 0; k < 4; k++) begin
            // Positive bits in [2:0], negative bits in [5:3]
            if (eta3) begin
                chunk = bits[6*k +: 6];
            end else begin
                chunk = {1'b0, bits[4*k+3], bits[4*k+2], 1'b0, bits[4*k+1], bits[4*k]};
            end
            pos_sum = 3'(chunk[0]) + 3'(chunk[1]) + 3'(chunk[2]);
            neg_sum = 3'(chunk[3]) + 3'(chunk[4]) + 3'(chunk[5]);
            // Difference lies in -3..3 so one add of q corrects it
            if (pos_sum >= neg_sum) begin
                lane[k] = sampler_pkg::coef_t'(pos_sum - neg_sum);
            end else begin
                lane[k] = sampler_pkg::coef_t'(sampler_pkg::Q)
                        - sampler_pkg::coef_t'(neg_sum - pos_sum);
            end
        end
    end

    always_comb begin
        coefs.c0    = lane[0];
        coefs.c1    = lane[1];
        coefs.c2    = lane[2];
        coefs.c3    = lane[3];
        // Every step yields four coefficients
        coefs.count = 3'd4;
    end

endmodule

`default_nettype wire

// File: hw/coef_store.sv
`default_nettype none

module coef_store (
    input  wire                          clk,
    input  wire                          run,
    input  wire sampler_pkg::coef_cnt_t  coef_base,
    input  wire sampler_pkg::coef_group_t coefs,
    input  wire sampler_pkg::coef_idx_t  rd_addr,
    output sampler_pkg::coef_t           rd_data
);

    sampler_pkg::coef_t mem [sampler_pkg::N_COEF];
    sampler_pkg::coef_t lane [4];

    always_comb begin
        lane[0] = coefs.c0;
        lane[1] = coefs.c1;
        lane[2] = coefs.c2;
        lane[3] = coefs.c3;
    end

    // Up to four writes per cycle, lanes above count are skipped
    always_ff @(posedge clk) begin
        if (run) begin
            for (int k = 0; k < 4; k++) begin
                if (sampler_pkg::lane_cnt_t'(k) < coefs.count) begin
                    mem[sampler_pkg::coef_idx_t'(coef_base + sampler_pkg::coef_cnt_t'(k))]
                        <= lane[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hw/poly_sampler_top.sv
`default_nettype none

module poly_sampler_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire sampler_pkg::mode_t      mode,
    input  wire                          load,
    input  wire sampler_pkg::byte_addr_t load_addr,
    input  wire sampler_pkg::byte_t      load_byte,
    input  wire                          start,
    output logic                         busy,
    output logic                         done,
    output logic                         short,
    input  wire sampler_pkg::coef_idx_t  rd_addr,
    output sampler_pkg::coef_t           rd_data
);

    logic                     run;
    logic                     clear;
    logic                     finished;
    logic                     exhausted;
    sampler_pkg::mode_t       mode_q;
    sampler_pkg::byte_addr_t  byte_pos;
    sampler_pkg::coef_cnt_t   coef_base;
    sampler_pkg::coef_cnt_t   room;
    sampler_pkg::byte_group_t group;
    sampler_pkg::coef_group_t ntt_coefs;
    sampler_pkg::coef_group_t cbd_coefs;
    sampler_pkg::coef_group_t wr_coefs;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    sampler_fsm i_fsm (
        .clk(clk), .rst(rst), .mode(mode), .start(start),
        .finished(finished), .exhausted(exhausted),
        .run(run), .clear(clear), .mode_q(mode_q),
        .busy(busy), .done(done), .short(short)
    );

    sample_counter i_counter (
        .clk(clk), .rst(rst), .clear(clear), .run(run), .mode_q(mode_q),
        .lanes(wr_coefs.count), .byte_pos(byte_pos), .coef_base(coef_base),
        .finished(finished), .exhausted(exhausted)
    );

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////

    byte_buffer i_buffer (
        .clk(clk), .load(load), .busy(busy), .load_addr(load_addr),
        .load_byte(load_byte), .byte_pos(byte_pos), .group(group)
    );

    // Free slots left in the polynomial
    assign room = sampler_pkg::coef_cnt_t'(sampler_pkg::N_COEF) - coef_base;

    reject_sampler i_reject (.group(group), .room(room), .coefs(ntt_coefs));

    cbd_sampler i_cbd (.group(group), .mode_q(mode_q), .coefs(cbd_coefs));

    assign wr_coefs = (mode_q == sampler_pkg::MODE_NTT) ? ntt_coefs : cbd_coefs;

    coef_store i_store (
        .clk(clk), .run(run), .coef_base(coef_base), .coefs(wr_coefs),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// File: hw/reject_sampler.sv
`default_nettype none

module reject_sampler (
    input  wire sampler_pkg::byte_group_t group,
    input  wire sampler_pkg::coef_cnt_t   room,
    output sampler_pkg::coef_group_t      coefs
);

    sampler_pkg::coef_t     d1;
    sampler_pkg::coef_t     d2;
    logic                   acc1;
    logic                   acc2;
    sampler_pkg::lane_cnt_t raw;

    // Two 12-bit candidates from 24 bits
    assign d1 = {group.b1[3:0], group.b0};
    assign d2 = {group.b2, group.b1[7:4]};

    assign acc1 = (d1 < sampler_pkg::coef_t'(sampler_pkg::Q));
    assign acc2 = (d2 < sampler_pkg::coef_t'(sampler_pkg::Q));
    assign raw  = sampler_pkg::lane_cnt_t'(acc1) + sampler_pkg::lane_cnt_t'(acc2);

    always_comb begin
        coefs = '0;
        // Accepted values fill the low lanes in order
        if (acc1) begin
            coefs.c0 = d1;
            coefs.c1 = d2;
        end else begin
            coefs.c0 = d2;
        end
        // Drop the second value when only one slot is left
        if (sampler_pkg::coef_cnt_t'(raw) > room) begin
            coefs.count = sampler_pkg::lane_cnt_t'(room);
        end else begin
            coefs.count = raw;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_counter.sv
`default_nettype none

module sample_counter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        clear,
    input  wire                        run,
    input  wire sampler_pkg::mode_t    mode_q,
    input  wire sampler_pkg::lane_cnt_t lanes,
    output sampler_pkg::byte_addr_t    byte_pos,
    output sampler_pkg::coef_cnt_t     coef_base,
    output logic                       finished,
    output logic                       exhausted
);

    sampler_pkg::byte_addr_t stride;
    // Address of the group now at the buffer output
    sampler_pkg::byte_addr_t pos_q;
    sampler_pkg::coef_cnt_t  base_next;
    logic [9:0]              reach;

    always_comb begin
        case (mode_q)
            sampler_pkg::MODE_CBD2: stride = sampler_pkg::byte_addr_t'(sampler_pkg::STRIDE_CBD2);
            sampler_pkg::MODE_CBD3: stride = sampler_pkg::byte_addr_t'(sampler_pkg::STRIDE_CBD3);
            default:                stride = sampler_pkg::byte_addr_t'(sampler_pkg::STRIDE_NTT);
        endcase
    end

    // Read address runs one group ahead while sampling
    assign byte_pos = run ? pos_q + stride : pos_q;

    assign base_next = coef_base + sampler_pkg::coef_cnt_t'(lanes);
    assign finished  = (base_next >= sampler_pkg::coef_cnt_t'(sampler_pkg::N_COEF));

    // End of the next group in bytes
    assign reach     = 10'(pos_q) + 10'(stride) + 10'(stride);
    assign exhausted = (mode_q == sampler_pkg::MODE_NTT)
                    && (reach > 10'(sampler_pkg::BYTE_BUF_DEPTH));

    always_ff @(posedge clk) begin
        if (!rst) begin
            pos_q     <= '0;
            coef_base <= '0;
        end else if (clear) begin
            pos_q     <= '0;
            coef_base <= '0;
        end else if (run) begin
            pos_q     <= pos_q + stride;
            coef_base <= base_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/sampler_fsm.sv
`default_nettype none

module sampler_fsm (
    input  wire                 clk,
    input  wire                 rst,
    input  wire sampler_pkg::mode_t mode,
    input  wire                 start,
    input  wire                 finished,
    input  wire                 exhausted,
    output logic                run,
    output logic                clear,
    output sampler_pkg::mode_t  mode_q,
    output logic                busy,
    output logic                done,
    output logic                short
);

    sampler_pkg::sampler_state_t state;
    sampler_pkg::sampler_state_t state_next;
    logic accept;
    logic stop;

    // Start only counts when nothing is in progress
    assign accept = start && (state == sampler_pkg::ST_IDLE || state == sampler_pkg::ST_DONE);
    assign stop   = finished || exhausted;

    always_comb begin
        state_next = state;
        case (state)
            sampler_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = sampler_pkg::ST_FILL;
                end
            end
            // One cycle for the registered buffer read
            sampler_pkg::ST_FILL: state_next = sampler_pkg::ST_RUN;
            sampler_pkg::ST_RUN: begin
                if (stop) begin
                    state_next = sampler_pkg::ST_DONE;
                end
            end
            default: begin
                if (accept) begin
                    state_next = sampler_pkg::ST_FILL;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= sampler_pkg::ST_IDLE;
            mode_q <= sampler_pkg::MODE_NTT;
            done   <= 1'b0;
            short  <= 1'b0;
        end else begin
            state <= state_next;
            if (accept) begin
                mode_q <= mode;
                done   <= 1'b0;
                short  <= 1'b0;
            end else begin
                // Done follows the cycle of the last store
                if (state == sampler_pkg::ST_DONE) begin
                    done <= 1'b1;
                end
                if (state == sampler_pkg::ST_RUN && stop) begin
                    short <= exhausted && !finished;
                end
            end
        end
    end

    assign run   = (state == sampler_pkg::ST_RUN);
    assign clear = accept;
    assign busy  = (state == sampler_pkg::ST_FILL) || (state == sampler_pkg::ST_RUN);

endmodule

`default_nettype wire

// File: hw/sampler_pkg.sv
`default_nettype none

package sampler_pkg;

    ////////////////////////////////////////
    // Sizes and modulus
    ////////////////////////////////////////

    localparam int Q              = 3329;
    localparam int N_COEF         = 256;
    // Three SHAKE128 blocks of 168 bytes
    localparam int BYTE_BUF_DEPTH = 504;

    typedef logic [1:0]  mode_t;
    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  byte_addr_t;
    typedef logic [11:0] coef_t;
    typedef logic [7:0]  coef_idx_t;
    typedef logic [8:0]  coef_cnt_t;
    typedef logic [2:0]  lane_cnt_t;

    localparam mode_t MODE_NTT  = 2'd0;
    localparam mode_t MODE_CBD2 = 2'd1;
    localparam mode_t MODE_CBD3 = 2'd2;

    // Bytes consumed per step
    localparam int STRIDE_NTT  = 3;
    localparam int STRIDE_CBD2 = 2;
    localparam int STRIDE_CBD3 = 3;

    ////////////////////////////////////////
    // Grouped data
    ////////////////////////////////////////

    typedef struct packed {
        byte_t b0;
        byte_t b1;
        byte_t b2;
    } byte_group_t;

    typedef struct packed {
        coef_t     c0;
        coef_t     c1;
        coef_t     c2;
        coef_t     c3;
        lane_cnt_t count;
    } coef_group_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_RUN,
        ST_DONE
    } sampler_state_t;

endpackage

`default_nettype wire

// File: tb/sampler_ref.svh
`ifndef SAMPLER_REF_SVH
`define SAMPLER_REF_SVH

////////////////////////////////////////
// Reference sampling models
////////////////////////////////////////

// Rejection sampling over 12-bit candidates, stops at 256 values
function automatic void ref_ntt();
    int count;
    int d1;
    int d2;
    count = 0;
    for (int pos = 0; pos + 3 <= sampler_pkg::BYTE_BUF_DEPTH; pos += 3) begin
        d1 = int'(bytes[pos]) + 256 * (int'(bytes[pos + 1]) % 16);
        d2 = int'(bytes[pos + 1]) / 16 + 16 * int'(bytes[pos + 2]);
        if (d1 < sampler_pkg::Q && count < sampler_pkg::N_COEF) begin
            expected[count] = sampler_pkg::coef_t'(d1);
            count++;
        end
        if (d2 < sampler_pkg::Q && count < sampler_pkg::N_COEF) begin
            expected[count] = sampler_pkg::coef_t'(d2);
            count++;
        end
    end
    ref_count = count;
    // Ran out of bytes before the polynomial was full
    exp_short = (count < sampler_pkg::N_COEF);
endfunction

// Bit j of the byte stream, LSB of byte 0 first
function automatic int stream_bit(input int j);
    return int'(bytes[j / 8][j % 8]);
endfunction

// Centered binomial with eta ones minus eta ones
function automatic void ref_cbd(input int eta);
    int a;
    int b;
    int diff;
    for (int i = 0; i < sampler_pkg::N_COEF; i++) begin
        a = 0;
        b = 0;
        for (int k = 0; k < eta; k++) begin
            a += stream_bit(2 * eta * i + k);
            b += stream_bit(2 * eta * i + eta + k);
        end
        diff = a - b;
        if (diff < 0) begin
            diff += sampler_pkg::Q;
        end
        expected[i] = sampler_pkg::coef_t'(diff);
    end
    ref_count = sampler_pkg::N_COEF;
    exp_short = 1'b0;
endfunction

`endif

// File: tb/tb_poly_sampler.sv
`default_nettype none

module tb_poly_sampler;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WATCHDOG_NS = 6 * (504 + 200 + 260) * 4 + 4000;
    localparam int CBD_LATENCY = 66;

    logic                    clk;
    logic                    rst;
    sampler_pkg::mode_t      mode;
    logic                    load;
    sampler_pkg::byte_addr_t load_addr;
    sampler_pkg::byte_t      load_byte;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic                    short;
    sampler_pkg::coef_idx_t  rd_addr;
    sampler_pkg::coef_t      rd_data;

    sampler_pkg::byte_t bytes [sampler_pkg::BYTE_BUF_DEPTH];
    sampler_pkg::coef_t expected [sampler_pkg::N_COEF];
    int                 ref_count;
    bit                 exp_short;
    int                 coef_errors;
    int                 flag_errors;
    int                 other_errors;
    event               compare_req;
    event               compare_ack;

    `include "sampler_ref.svh"

    poly_sampler_top i_dut (
        .clk(clk), .rst(rst), .mode(mode), .load(load), .load_addr(load_addr),
        .load_byte(load_byte), .start(start), .busy(busy), .done(done),
        .short(short), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the run did not complete", $time);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic check_coef(input string name, input sampler_pkg::coef_t exp_v,
                              input sampler_pkg::coef_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
            coef_errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %0t %s expected %0b got %0b", $time, name, exp_v, act_v);
            flag_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
            other_errors++;
        end
    endtask

    // Reads back every address once a run has finished
    initial begin : compare
        forever begin
            @(compare_req);
            for (int a = 0; a < sampler_pkg::N_COEF; a++) begin
                rd_addr = sampler_pkg::coef_idx_t'(a);
                @(posedge clk);
                #1;
                if (a < ref_count) begin
                    check_coef($sformatf("rd_data[%0d]", a), expected[a], rd_data);
                end
            end
            check_flag("short", exp_short, short);
            -> compare_ack;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic void fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            bytes[i] = sampler_pkg::byte_t'($urandom);
        end
    endfunction

    // Mostly 0xFF so nearly all candidates are rejected
    function automatic void fill_sparse();
        for (int i = 0; i < sampler_pkg::BYTE_BUF_DEPTH; i++) begin
            bytes[i] = ($urandom_range(3) == 0) ? sampler_pkg::byte_t'($urandom) : 8'hFF;
        end
    endfunction

    // 3328 kept and 3329 rejected, then 254 kept, then slot 256 from a full pair
    function automatic void fill_boundary();
        int d1;
        int d2;
        bytes[0] = 8'h00;
        bytes[1] = 8'h1D;
        bytes[2] = 8'hD0;
        for (int g = 1; g < sampler_pkg::BYTE_BUF_DEPTH / 3; g++) begin
            d1 = (g <= 128) ? (g * 37) % sampler_pkg::Q : 4095;
            d2 = (g <= 128) ? (g * 53 + 11) % sampler_pkg::Q : 4095;
            bytes[3 * g]     = sampler_pkg::byte_t'(d1 % 256);
            bytes[3 * g + 1] = sampler_pkg::byte_t'(d1 / 256 + 16 * (d2 % 16));
            bytes[3 * g + 2] = sampler_pkg::byte_t'(d2 / 16);
        end
    endfunction

    task automatic load_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            load      = 1'b1;
            load_addr = sampler_pkg::byte_addr_t'(i);
            load_byte = bytes[i];
            @(posedge clk);
            #1;
        end
        load = 1'b0;
    endtask

    // Disturb adds a stray start and overwrites of unread bytes mid-run
    task automatic run_sampler(input sampler_pkg::mode_t m, input int n, input bit disturb);
        int cycles;
        load_bytes(n);
        mode  = m;
        start = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        check_flag("busy", 1'b1, busy);
        cycles = 0;
        while (!done && cycles < 1000) begin
            start = disturb && cycles == 5;
            load  = 1'b0;
            if (disturb && cycles >= 10 && cycles < 40) begin
                load      = 1'b1;
                load_addr = sampler_pkg::byte_addr_t'(90 + cycles);
                load_byte = ~bytes[90 + cycles];
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        start = 1'b0;
        load  = 1'b0;
        if (!done) begin
            $display("Timeout at %0t: done did not rise within 1000 cycles", $time);
            other_errors++;
        end else begin
            check_flag("busy", 1'b0, busy);
            if (m != sampler_pkg::MODE_NTT) begin
                check_latency("done latency", CBD_LATENCY, cycles);
            end
        end
        -> compare_req;
        @(compare_ack);
    endtask

    initial begin : main
        void'($urandom(21));
        coef_errors  = 0;
        flag_errors  = 0;
        other_errors = 0;
        rst       = 1'b0;
        mode      = sampler_pkg::MODE_NTT;
        load      = 1'b0;
        load_addr = '0;
        load_byte = '0;
        start     = 1'b0;
        rd_addr   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_flag("short", 1'b0, short);

        fill_random(sampler_pkg::BYTE_BUF_DEPTH);
        ref_ntt();
        run_sampler(sampler_pkg::MODE_NTT, sampler_pkg::BYTE_BUF_DEPTH, 1'b0);
        fill_sparse();
        ref_ntt();
        run_sampler(sampler_pkg::MODE_NTT, sampler_pkg::BYTE_BUF_DEPTH, 1'b0);
        // eta 2 straight after a short run
        fill_random(128);
        ref_cbd(2);
        run_sampler(sampler_pkg::MODE_CBD2, 128, 1'b0);
        fill_random(192);
        ref_cbd(3);
        run_sampler(sampler_pkg::MODE_CBD3, 192, 1'b0);
        fill_boundary();
        ref_ntt();
        run_sampler(sampler_pkg::MODE_NTT, sampler_pkg::BYTE_BUF_DEPTH, 1'b0);
        fill_random(128);
        ref_cbd(2);
        run_sampler(sampler_pkg::MODE_CBD2, 128, 1'b1);

        $display("Errors: %0d coefficient, %0d flag, %0d other",
                 coef_errors, flag_errors, other_errors);
        if (coef_errors + flag_errors + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
